//--- dv/decode_tb.sv
/*
 * Testbench for decode_top with M_ENABLE and COMPRESSED set.
 * Inputs change on the rising edge, outputs are checked on the falling
 * edge against a reference model with its own lock state.
 * The register bank is a fixed hash of the read address.
 */
`timescale 1ns/100ps

module decode_tb;
    import rv_decode_pkg::*;

    localparam int  STIM_CYCLES = 320;
    localparam int  TIMEOUT_NS  = (STIM_CYCLES + 5 + 50) * 100;
    localparam word_t M_ALL = 32'hFFFF8F80;
    localparam word_t M_R   = 32'h01FF8F80;
    localparam word_t M_UJ  = 32'hFFFFFF80;

    typedef struct {
        word_t     instr;
        inst_op_e  op;
        word_t     pc;
        logic      flush;
        logic      enable;
        logic      exec_we;
        logic      ret_we;
        word_t     result;
        word_t     wb;
        reg_addr_t ret_rd;
    } stim_t;

    typedef struct packed {
        issue_t iss;
        logic   killed;
        logic   ill;
        logic   mis;
    } expect_t;

    logic clk;
    logic reset_n;
    stim_t cur;
    stim_t stim_q[$];
    word_t tpl_word[$];
    word_t tpl_mask[$];
    inst_op_e tpl_op[$];
    expect_t pending;
    expect_t nxt;
    logic hz;
    reg_addr_t lreg;
    logic lmem;
    int errors = 0;
    int checks = 0;
    int tests = 0;

    reg_addr_t rs1_o;
    reg_addr_t rs2_o;
    issue_t issue_o;
    logic hazard_o;
    logic killed_o;
    logic exc_illegal_o;
    logic exc_misaligned_o;

    tb_clock_gen i_clock_gen (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    decode_top #(
        .M_ENABLE   (1'b1),
        .COMPRESSED (1'b1)
    ) i_dut (
        .clk              (clk),
        .reset_n          (reset_n),
        .enable_i         (cur.enable),
        .flush_i          (cur.flush),
        .instruction_i    (cur.instr),
        .pc_i             (cur.pc),
        .rs1_data_read_i  (bank_word(rs1_o)),
        .rs2_data_read_i  (bank_word(rs2_o)),
        .result_i         (cur.result),
        .writeback_i      (cur.wb),
        .execute_we_i     (cur.exec_we),
        .regbank_we_i     (cur.ret_we),
        .rd_retire_i      (cur.ret_rd),
        .rs1_o            (rs1_o),
        .rs2_o            (rs2_o),
        .issue_o          (issue_o),
        .hazard_o         (hazard_o),
        .killed_o         (killed_o),
        .exc_illegal_o    (exc_illegal_o),
        .exc_misaligned_o (exc_misaligned_o)
    );

    function automatic word_t bank_word(input reg_addr_t a);
        return 32'h9E3779B9 * (a + 1);
    endfunction

    function automatic inst_fmt_e fmt_of(input opcode_t opc);
        case (opc)
            OPC_LUI, OPC_AUIPC:             return U_TYPE;
            OPC_JAL:                        return J_TYPE;
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: return I_TYPE;
            OPC_STORE:                      return S_TYPE;
            OPC_BRANCH:                     return B_TYPE;
            default:                        return R_TYPE;
        endcase
    endfunction

    function automatic word_t imm_of(input inst_fmt_e f, input word_t w);
        case (f)
            I_TYPE:  return {{20{w[31]}}, w[31:20]};
            S_TYPE:  return {{20{w[31]}}, w[31:25], w[11:7]};
            B_TYPE:  return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            U_TYPE:  return {w[31:12], 12'h000};
            J_TYPE:  return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: return '0;
        endcase
    endfunction

    // Execute wins for a nonzero rd, then retire, then the bank
    function automatic word_t operand_of(input reg_addr_t rs, input stim_t v,
                                         input reg_addr_t prev_rd);
        if (v.exec_we && prev_rd != 0 && prev_rd == rs) begin
            return v.result;
        end else if (v.ret_we && v.ret_rd == rs) begin
            return v.wb;
        end
        return bank_word(rs);
    endfunction

    function automatic expect_t ref_issue(input stim_t v, input reg_addr_t lr, input logic lm,
                                          input reg_addr_t prev_rd, output logic hazard);
        expect_t e;
        inst_fmt_e f;
        logic use1;
        logic use2;
        word_t d2;
        f = fmt_of(v.instr[6:2]);
        use1 = (f != U_TYPE) && (f != J_TYPE);
        use2 = (f == R_TYPE) || (f == S_TYPE) || (f == B_TYPE);
        d2 = operand_of(v.instr[24:20], v, prev_rd);
        e.mis = v.pc[0] && !v.flush;
        e.ill = ((v.instr[1:0] != 2'b11) || (v.op == INVALID)) && !v.flush;
        e.killed = v.flush;
        hazard = ((use1 && lr != 0 && lr == v.instr[19:15])
                 || (use2 && lr != 0 && lr == v.instr[24:20])
                 || (lm && v.instr[6:2] == OPC_LOAD)) && !v.flush && !e.ill && !e.mis;
        e.iss.op = (hazard || v.flush) ? NOP : v.op;
        e.iss.rd = v.instr[11:7];
        e.iss.pc = v.pc;
        e.iss.instruction = v.instr;
        e.iss.rs1_data = operand_of(v.instr[19:15], v, prev_rd);
        e.iss.rs2_data = d2;
        e.iss.second_operand = (f == I_TYPE || f == S_TYPE || f == U_TYPE)
                               ? imm_of(f, v.instr) : d2;
        return e;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic stim_t vec(input word_t w, input inst_op_e op);
        stim_t v;
        v.instr = w;
        v.op = op;
        v.pc = $urandom;
        v.pc[0] = 1'b0;
        v.flush = 1'b0;
        v.enable = 1'b1;
        v.exec_we = 1'b0;
        v.ret_we = 1'b0;
        v.result = '0;
        v.wb = '0;
        v.ret_rd = '0;
        return v;
    endfunction

    function automatic stim_t rand_vec(input int idx);
        word_t r;
        r = $urandom;
        return vec((tpl_word[idx] & ~tpl_mask[idx]) | (r & tpl_mask[idx]), tpl_op[idx]);
    endfunction

    task automatic add_raw(input word_t w, input word_t mask, input inst_op_e op);
        tpl_word.push_back(w);
        tpl_mask.push_back(mask);
        tpl_op.push_back(op);
    endtask

    task automatic add_tpl(input logic [6:0] f7, input logic [2:0] f3, input logic [6:0] opc,
                           input word_t mask, input inst_op_e op);
        add_raw({f7, 10'b0, f3, 5'b0, opc}, mask, op);
    endtask

    ////////////////////
    // Instruction table
    ////////////////////
    task automatic build_table();
        add_tpl(0, 0, 7'h37, M_UJ, LUI);
        add_tpl(0, 0, 7'h17, M_UJ, AUIPC);
        add_tpl(0, 0, 7'h6F, M_UJ, JAL);
        add_tpl(0, 0, 7'h67, M_ALL, JALR);
        for (int i = 0; i < 6; i++) begin
            add_tpl(0, (i < 2) ? i : i + 2, 7'h63, M_ALL, inst_op_e'(BEQ + i));
        end
        for (int i = 0; i < 5; i++) begin
            add_tpl(0, (i < 3) ? i : i + 1, 7'h03, M_ALL, inst_op_e'(LB + i));
        end
        for (int i = 0; i < 3; i++) begin
            add_tpl(0, i, 7'h23, M_ALL, inst_op_e'(SB + i));
        end
        add_tpl(0, 0, 7'h13, M_ALL, ADD);
        add_tpl(0, 2, 7'h13, M_ALL, SLT);
        add_tpl(0, 3, 7'h13, M_ALL, SLTU);
        add_tpl(0, 4, 7'h13, M_ALL, XOR);
        add_tpl(0, 6, 7'h13, M_ALL, OR);
        add_tpl(0, 7, 7'h13, M_ALL, AND);
        add_tpl(0, 1, 7'h13, M_R, SLL);
        add_tpl(0, 5, 7'h13, M_R, SRL);
        add_tpl(7'h20, 5, 7'h13, M_R, SRA);
        add_tpl(0, 0, 7'h33, M_R, ADD);
        add_tpl(7'h20, 0, 7'h33, M_R, SUB);
        add_tpl(0, 1, 7'h33, M_R, SLL);
        add_tpl(0, 2, 7'h33, M_R, SLT);
        add_tpl(0, 3, 7'h33, M_R, SLTU);
        add_tpl(0, 4, 7'h33, M_R, XOR);
        add_tpl(0, 5, 7'h33, M_R, SRL);
        add_tpl(7'h20, 5, 7'h33, M_R, SRA);
        add_tpl(0, 6, 7'h33, M_R, OR);
        add_tpl(0, 7, 7'h33, M_R, AND);
        for (int i = 0; i < 8; i++) begin
            add_tpl(1, i, 7'h33, M_R, inst_op_e'(MUL + i));
        end
        add_tpl(0, 0, 7'h0F, M_ALL, NOP);
        add_raw(32'h00000073, 0, ECALL);
        add_raw(32'h00100073, 0, EBREAK);
        add_raw(32'h10200073, 0, SRET);
        add_raw(32'h30200073, 0, MRET);
        add_raw(32'h10500073, 0, WFI);
        for (int i = 0; i < 6; i++) begin
            add_tpl(0, (i < 3) ? i + 1 : i + 2, 7'h73, M_ALL, inst_op_e'(CSRRW + i));
        end
        // Illegal forms
        add_raw(32'h00000030, M_R, INVALID);
        add_tpl(7'h7F, 0, 7'h33, M_R, INVALID);
        add_tpl(0, 2, 7'h63, M_ALL, INVALID);
        add_tpl(0, 0, 7'h0B, M_ALL, INVALID);
        add_tpl(0, 4, 7'h73, M_ALL, INVALID);
    endtask

    task automatic run_test(input string name);
        int err_before;
        int n;
        err_before = errors;
        n = stim_q.size();
        stim_q.push_back(vec(32'h00000013, ADD));
        while (stim_q.size() > 0) begin
            @(posedge clk);
            cur <= stim_q.pop_front();
        end
        repeat (2) @(posedge clk);
        tests++;
        $display("test %s: %0d vectors, %0d errors", name, n, errors - err_before);
    endtask

    // Reference lock state follows each enabled edge
    initial begin
        pending = '0;
        pending.iss.op = NOP;
        lreg = '0;
        lmem = 1'b0;
        @(posedge reset_n);
        forever begin
            @(negedge clk);
            check("issue_o.op", issue_o.op, pending.iss.op);
            check("issue_o.rd", issue_o.rd, pending.iss.rd);
            check("issue_o.pc", issue_o.pc, pending.iss.pc);
            check("issue_o.instruction", issue_o.instruction, pending.iss.instruction);
            check("issue_o.rs1_data", issue_o.rs1_data, pending.iss.rs1_data);
            check("issue_o.rs2_data", issue_o.rs2_data, pending.iss.rs2_data);
            check("issue_o.second_operand", issue_o.second_operand, pending.iss.second_operand);
            check("killed_o", killed_o, pending.killed);
            check("exc_illegal_o", exc_illegal_o, pending.ill);
            check("exc_misaligned_o", exc_misaligned_o, pending.mis);
            check("rs1_o", rs1_o, cur.instr[19:15]);
            check("rs2_o", rs2_o, cur.instr[24:20]);
            nxt = ref_issue(cur, lreg, lmem, pending.iss.rd, hz);
            check("hazard_o", hazard_o, hz);
            if (cur.enable) begin
                pending = nxt;
                if (hz || cur.flush) begin
                    lreg = '0;
                    lmem = 1'b0;
                end else begin
                    lreg = (cur.instr[6:2] == OPC_LOAD) ? cur.instr[11:7] : '0;
                    lmem = (cur.instr[6:2] == OPC_STORE);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout, the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TB FAILED");
        $finish;
    end

    ////////////////////
    // Stimulus
    ////////////////////
    initial begin
        stim_t v;
        word_t fld;
        word_t m;
        int idx;
        void'($urandom(52453));
        cur = vec(32'h00000013, ADD);
        cur.enable = 1'b0;
        build_table();
        @(posedge reset_n);

        foreach (tpl_word[i]) begin
            repeat (3) stim_q.push_back(rand_vec(i));
        end
        run_test("decode");

        repeat (40) stim_q.push_back(rand_vec($urandom % tpl_word.size()));
        run_test("immediate");

        // Execute beats retire, then retire alone, then x0 from execute
        stim_q.push_back(vec(32'h00208533 & 32'hFFFFF07F | (5 << 7), ADD));
        v = vec({7'd0, 5'd5, 5'd5, 3'd0, 5'd1, 7'h33}, ADD);
        v.exec_we = 1'b1;
        v.result = 32'hAAAA5555;
        v.ret_we = 1'b1;
        v.ret_rd = 5;
        v.wb = 32'h12345678;
        stim_q.push_back(v);
        v = vec({7'd0, 5'd7, 5'd7, 3'd0, 5'd0, 7'h33}, ADD);
        v.ret_we = 1'b1;
        v.ret_rd = 7;
        v.wb = 32'hCAFE0007;
        stim_q.push_back(v);
        v = vec({7'd0, 5'd0, 5'd0, 3'd0, 5'd2, 7'h33}, ADD);
        v.exec_we = 1'b1;
        v.result = 32'hDEAD0000;
        stim_q.push_back(v);
        // Small register range so locks and forwards collide often
        repeat (40) begin
            idx = $urandom % tpl_word.size();
            v = rand_vec(idx);
            fld = (($urandom % 4) << 20) | (($urandom % 4) << 15) | (($urandom % 4) << 7);
            m = tpl_mask[idx] & M_R;
            v.instr = (v.instr & ~m) | (fld & m);
            v.exec_we = ($urandom % 2) != 0;
            v.ret_we = ($urandom % 2) != 0;
            v.ret_rd = reg_addr_t'($urandom % 4);
            v.result = $urandom;
            v.wb = $urandom;
            v.flush = ($urandom % 8) == 0;
            v.enable = ($urandom % 8) != 0;
            v.pc[0] = ($urandom % 10) == 0;
            stim_q.push_back(v);
        end
        run_test("forwarding");

        stim_q.push_back(vec({12'h0, 5'd1, 3'd2, 5'd5, 7'h03}, LW));
        stim_q.push_back(vec({7'd0, 5'd1, 5'd5, 3'd0, 5'd6, 7'h33}, ADD));
        stim_q.push_back(vec({12'h0, 5'd1, 3'd2, 5'd5, 7'h03}, LW));
        stim_q.push_back(vec({7'd0, 5'd5, 5'd1, 3'd0, 5'd6, 7'h13}, ADD));
        stim_q.push_back(vec({7'd0, 5'd1, 5'd2, 3'd2, 5'd0, 7'h23}, SW));
        stim_q.push_back(vec({12'h0, 5'd1, 3'd2, 5'd5, 7'h03}, LW));
        run_test("hazard");

        v = vec({12'h0, 5'd1, 3'd2, 5'd5, 7'h03}, LW);
        v.flush = 1'b1;
        stim_q.push_back(v);
        stim_q.push_back(vec({7'd0, 5'd1, 5'd5, 3'd0, 5'd6, 7'h33}, ADD));
        v = vec(32'h00000030, INVALID);
        v.flush = 1'b1;
        v.pc[0] = 1'b1;
        stim_q.push_back(v);
        run_test("flush");

        stim_q.push_back(vec({12'h0, 5'd1, 3'd2, 5'd5, 7'h03}, LW));
        repeat (3) begin
            v = rand_vec($urandom % tpl_word.size());
            v.enable = 1'b0;
            stim_q.push_back(v);
        end
        v = vec({7'd0, 5'd1, 5'd5, 3'd0, 5'd6, 7'h33}, ADD);
        v.pc[0] = 1'b1;
        stim_q.push_back(v);
        run_test("enable_mis");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- dv/tb_clock_gen.sv
/*
 * Free-running testbench clock and active low reset.
 * Reset is released on a rising edge after RESET_CYCLES edges.
 */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic reset_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_n_o <= 1'b1;
    end

endmodule

//--- rtl/decode_top.sv
/*
 * Decode stage of a small in-order RV32 core.
 * No handshake. enable_i is a level and a stall from later stages
 * must hold it low. rs1_o and rs2_o are combinational, so the
 * register bank has to answer in the same cycle.
 * issue_o and the flags are valid one edge after the sampling edge.
 */
`timescale 1ns/100ps

module decode_top #(
    parameter bit M_ENABLE   = 1'b1,
    parameter bit COMPRESSED = 1'b1
) (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     enable_i,
    input  logic                     flush_i,
    input  rv_decode_pkg::word_t     instruction_i,
    input  rv_decode_pkg::word_t     pc_i,
    input  rv_decode_pkg::word_t     rs1_data_read_i,
    input  rv_decode_pkg::word_t     rs2_data_read_i,
    input  rv_decode_pkg::word_t     result_i,
    input  rv_decode_pkg::word_t     writeback_i,
    input  logic                     execute_we_i,
    input  logic                     regbank_we_i,
    input  rv_decode_pkg::reg_addr_t rd_retire_i,
    output rv_decode_pkg::reg_addr_t rs1_o,
    output rv_decode_pkg::reg_addr_t rs2_o,
    output rv_decode_pkg::issue_t    issue_o,
    output logic                     hazard_o,
    output logic                     killed_o,
    output logic                     exc_illegal_o,
    output logic                     exc_misaligned_o
);
    import rv_decode_pkg::*;

    dec_info_t dec;
    fwd_src_t  exec_fwd;
    fwd_src_t  ret_fwd;
    word_t     rs1_data;
    word_t     rs2_data;

    // Execute writes the rd issued on the previous edge
    assign exec_fwd = '{we: execute_we_i, rd: issue_o.rd, data: result_i};
    assign ret_fwd  = '{we: regbank_we_i, rd: rd_retire_i, data: writeback_i};

    assign rs1_o = dec.rs1;
    assign rs2_o = dec.rs2;

    op_decoder #(
        .M_ENABLE (M_ENABLE)
    ) i_op_decoder (
        .instruction_i (instruction_i),
        .dec_o         (dec)
    );

    operand_forward i_operand_forward (
        .rs1_i      (dec.rs1),
        .rs2_i      (dec.rs2),
        .exec_fwd_i (exec_fwd),
        .ret_fwd_i  (ret_fwd),
        .rs1_bank_i (rs1_data_read_i),
        .rs2_bank_i (rs2_data_read_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    issue_ctrl #(
        .COMPRESSED (COMPRESSED)
    ) i_issue_ctrl (
        .clk              (clk),
        .reset_n          (reset_n),
        .enable_i         (enable_i),
        .flush_i          (flush_i),
        .dec_i            (dec),
        .pc_i             (pc_i),
        .instruction_i    (instruction_i),
        .rs1_data_i       (rs1_data),
        .rs2_data_i       (rs2_data),
        .hazard_o         (hazard_o),
        .issue_o          (issue_o),
        .killed_o         (killed_o),
        .exc_illegal_o    (exc_illegal_o),
        .exc_misaligned_o (exc_misaligned_o)
    );

endmodule

//--- rtl/issue_ctrl.sv
/*
 * Hazard, flush and exception control plus the issue register.
 * enable_i low freezes every register, locks included.
 * A hazard issues a bubble and clears the locks, fetch must present
 * the same instruction again. Only one load destination is tracked.
 */
`timescale 1ns/100ps

module issue_ctrl #(
    parameter bit COMPRESSED = 1'b1
) (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      enable_i,
    input  logic                      flush_i,
    input  rv_decode_pkg::dec_info_t  dec_i,
    input  rv_decode_pkg::word_t      pc_i,
    input  rv_decode_pkg::word_t      instruction_i,
    input  rv_decode_pkg::word_t      rs1_data_i,
    input  rv_decode_pkg::word_t      rs2_data_i,
    output logic                      hazard_o,
    output rv_decode_pkg::issue_t     issue_o,
    output logic                      killed_o,
    output logic                      exc_illegal_o,
    output logic                      exc_misaligned_o
);
    import rv_decode_pkg::*;

    reg_addr_t locked_reg;
    logic      locked_mem;
    logic      hazard_rs1;
    logic      hazard_rs2;
    logic      hazard_mem;
    logic      illegal;
    logic      misaligned;
    logic      exception;
    word_t     second_operand;

    ////////////////////
    // Load/store locks
    ////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            locked_reg <= '0;
            locked_mem <= 1'b0;
        end else if (enable_i) begin
            if (hazard_o || flush_i) begin
                locked_reg <= '0;
                locked_mem <= 1'b0;
            end else begin
                locked_reg <= dec_i.is_load ? dec_i.rd : '0;
                locked_mem <= dec_i.is_store;
            end
        end
    end

    ////////////////////
    // Exceptions
    ////////////////////
    // With compressed support only halfword alignment is required
    assign misaligned = (COMPRESSED ? pc_i[0] : (pc_i[1:0] != 2'b00)) && !flush_i;
    assign illegal    = dec_i.illegal && !flush_i;
    assign exception  = illegal || misaligned;

    ////////////////////
    // Hazard
    ////////////////////
    assign hazard_rs1 = dec_i.use_rs1 && (locked_reg != '0) && (locked_reg == dec_i.rs1);
    assign hazard_rs2 = dec_i.use_rs2 && (locked_reg != '0) && (locked_reg == dec_i.rs2);

    // Load right behind a store waits one slot
    assign hazard_mem = locked_mem && dec_i.is_load;

    assign hazard_o = (hazard_rs1 || hazard_rs2 || hazard_mem) && !flush_i && !exception;

    // Immediate formats feed the ALU the immediate
    always_comb begin
        case (dec_i.fmt)
            I_TYPE, S_TYPE, U_TYPE: second_operand = dec_i.imm;
            default:                second_operand = rs2_data_i;
        endcase
    end

    ////////////////////
    // Issue register
    ////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            issue_o          <= '{op: NOP, default: '0};
            killed_o         <= 1'b0;
            exc_illegal_o    <= 1'b0;
            exc_misaligned_o <= 1'b0;
        end else if (enable_i) begin
            issue_o.op             <= (hazard_o || flush_i) ? NOP : dec_i.op;
            issue_o.rd             <= dec_i.rd;
            issue_o.pc             <= pc_i;
            issue_o.instruction    <= instruction_i;
            issue_o.rs1_data       <= rs1_data_i;
            issue_o.rs2_data       <= rs2_data_i;
            issue_o.second_operand <= second_operand;
            killed_o               <= flush_i;
            exc_illegal_o          <= illegal;
            exc_misaligned_o       <= misaligned;
        end
    end

endmodule

//--- rtl/op_decoder.sv
/*
 * Combinational RV32I decoder, M extension when M_ENABLE is set.
 * Only the 32-bit encoding is decoded. Low bits other than 11 give INVALID.
 * FENCE decodes as NOP. SYSTEM and MISC-MEM are treated as R format,
 * so they claim both sources. CSR immediate forms may therefore see a
 * spurious load-use stall, which is harmless.
 */
`timescale 1ns/100ps

module op_decoder #(
    parameter bit M_ENABLE = 1'b1
) (
    input  rv_decode_pkg::word_t     instruction_i,
    output rv_decode_pkg::dec_info_t dec_o
);
    import rv_decode_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    opcode_t    opcode;
    inst_op_e   op;
    inst_op_e   op_branch;
    inst_op_e   op_load;
    inst_op_e   op_store;
    inst_op_e   op_imm;
    inst_op_e   op_reg;
    inst_op_e   op_system;
    inst_fmt_e  fmt;
    word_t      imm;

    assign funct3 = instruction_i[14:12];
    assign funct7 = instruction_i[31:25];
    assign opcode = instruction_i[6:2];

    ////////////////////
    // Operation groups
    ////////////////////
    always_comb begin
        case (funct3)
            3'b000:  op_branch = BEQ;
            3'b001:  op_branch = BNE;
            3'b100:  op_branch = BLT;
            3'b101:  op_branch = BGE;
            3'b110:  op_branch = BLTU;
            3'b111:  op_branch = BGEU;
            default: op_branch = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  op_load = LB;
            3'b001:  op_load = LH;
            3'b010:  op_load = LW;
            3'b100:  op_load = LBU;
            3'b101:  op_load = LHU;
            default: op_load = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  op_store = SB;
            3'b001:  op_store = SH;
            3'b010:  op_store = SW;
            default: op_store = INVALID;
        endcase
    end

    // Shift immediates are the only ones that constrain funct7
    always_comb begin
        case ({funct7, funct3}) inside
            10'b???????000: op_imm = ADD;
            10'b0000000001: op_imm = SLL;
            10'b???????010: op_imm = SLT;
            10'b???????011: op_imm = SLTU;
            10'b???????100: op_imm = XOR;
            10'b0000000101: op_imm = SRL;
            10'b0100000101: op_imm = SRA;
            10'b???????110: op_imm = OR;
            10'b???????111: op_imm = AND;
            default:        op_imm = INVALID;
        endcase
    end

    always_comb begin
        case ({funct7, funct3})
            10'b0000000000: op_reg = ADD;
            10'b0100000000: op_reg = SUB;
            10'b0000000001: op_reg = SLL;
            10'b0000000010: op_reg = SLT;
            10'b0000000011: op_reg = SLTU;
            10'b0000000100: op_reg = XOR;
            10'b0000000101: op_reg = SRL;
            10'b0100000101: op_reg = SRA;
            10'b0000000110: op_reg = OR;
            10'b0000000111: op_reg = AND;
            10'b0000001000: op_reg = M_ENABLE ? MUL    : INVALID;
            10'b0000001001: op_reg = M_ENABLE ? MULH   : INVALID;
            10'b0000001010: op_reg = M_ENABLE ? MULHSU : INVALID;
            10'b0000001011: op_reg = M_ENABLE ? MULHU  : INVALID;
            10'b0000001100: op_reg = M_ENABLE ? DIV    : INVALID;
            10'b0000001101: op_reg = M_ENABLE ? DIVU   : INVALID;
            10'b0000001110: op_reg = M_ENABLE ? REM    : INVALID;
            10'b0000001111: op_reg = M_ENABLE ? REMU   : INVALID;
            default:        op_reg = INVALID;
        endcase
    end

    // Privileged forms need every field exact, CSR forms only funct3
    always_comb begin
        case (instruction_i[31:7]) inside
            25'b0000000000000000000000000: op_system = ECALL;
            25'b0000000000010000000000000: op_system = EBREAK;
            25'b0001000000100000000000000: op_system = SRET;
            25'b0011000000100000000000000: op_system = MRET;
            25'b0001000001010000000000000: op_system = WFI;
            25'b?????????????????001?????: op_system = CSRRW;
            25'b?????????????????010?????: op_system = CSRRS;
            25'b?????????????????011?????: op_system = CSRRC;
            25'b?????????????????101?????: op_system = CSRRWI;
            25'b?????????????????110?????: op_system = CSRRSI;
            25'b?????????????????111?????: op_system = CSRRCI;
            default:                       op_system = INVALID;
        endcase
    end

    ////////////////////
    // Opcode and format
    ////////////////////
    always_comb begin
        op = INVALID;
        if (instruction_i[1:0] == 2'b11) begin
            case (opcode)
                OPC_LUI:      op = LUI;
                OPC_AUIPC:    op = AUIPC;
                OPC_JAL:      op = JAL;
                OPC_JALR:     op = JALR;
                OPC_BRANCH:   op = op_branch;
                OPC_LOAD:     op = op_load;
                OPC_STORE:    op = op_store;
                OPC_OP_IMM:   op = op_imm;
                OPC_OP:       op = op_reg;
                OPC_MISC_MEM: op = (funct3 == 3'b000) ? NOP : INVALID;
                OPC_SYSTEM:   op = op_system;
                default:      op = INVALID;
            endcase
        end
    end

    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC:             fmt = U_TYPE;
            OPC_JAL:                        fmt = J_TYPE;
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: fmt = I_TYPE;
            OPC_BRANCH:                     fmt = B_TYPE;
            OPC_STORE:                      fmt = S_TYPE;
            default:                        fmt = R_TYPE;
        endcase
    end

    // Sign-extended immediate per format
    always_comb begin
        case (fmt)
            I_TYPE:  imm = {{21{instruction_i[31]}}, instruction_i[30:20]};
            S_TYPE:  imm = {{21{instruction_i[31]}}, instruction_i[30:25], instruction_i[11:7]};
            B_TYPE:  imm = {{20{instruction_i[31]}}, instruction_i[7], instruction_i[30:25],
                            instruction_i[11:8], 1'b0};
            U_TYPE:  imm = {instruction_i[31:12], 12'b0};
            J_TYPE:  imm = {{12{instruction_i[31]}}, instruction_i[19:12], instruction_i[20],
                            instruction_i[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        dec_o.op       = op;
        dec_o.fmt      = fmt;
        dec_o.rd       = instruction_i[11:7];
        dec_o.rs1      = instruction_i[19:15];
        dec_o.rs2      = instruction_i[24:20];
        dec_o.use_rs1  = (fmt != U_TYPE) && (fmt != J_TYPE);
        dec_o.use_rs2  = (fmt == R_TYPE) || (fmt == S_TYPE) || (fmt == B_TYPE);
        dec_o.is_load  = (opcode == OPC_LOAD);
        dec_o.is_store = (opcode == OPC_STORE);
        dec_o.illegal  = (op == INVALID);
        dec_o.imm      = imm;
    end

endmodule

//--- rtl/operand_forward.sv
/*
 * Operand bypass in front of the issue register.
 * Execute has priority over retire. Execute never forwards x0.
 * Retire data is taken as is, the bank is expected to ignore x0.
 */
`timescale 1ns/100ps

module operand_forward (
    input  rv_decode_pkg::reg_addr_t rs1_i,
    input  rv_decode_pkg::reg_addr_t rs2_i,
    input  rv_decode_pkg::fwd_src_t  exec_fwd_i,
    input  rv_decode_pkg::fwd_src_t  ret_fwd_i,
    input  rv_decode_pkg::word_t     rs1_bank_i,
    input  rv_decode_pkg::word_t     rs2_bank_i,
    output rv_decode_pkg::word_t     rs1_data_o,
    output rv_decode_pkg::word_t     rs2_data_o
);
    import rv_decode_pkg::*;

    function automatic word_t select_src(
        input reg_addr_t rs,
        input fwd_src_t  exec_src,
        input fwd_src_t  ret_src,
        input word_t     bank_word
    );
        word_t sel;
        if (exec_src.we && (exec_src.rd != '0) && (exec_src.rd == rs)) begin
            sel = exec_src.data;
        end else if (ret_src.we && (ret_src.rd == rs)) begin
            sel = ret_src.data;
        end else begin
            sel = bank_word;
        end
        return sel;
    endfunction

    assign rs1_data_o = select_src(rs1_i, exec_fwd_i, ret_fwd_i, rs1_bank_i);
    assign rs2_data_o = select_src(rs2_i, exec_fwd_i, ret_fwd_i, rs2_bank_i);

endmodule

//--- rtl/rv_decode_pkg.sv
/*
 * Shared types and constants for the RV32 decode stage.
 * Opcode constants hold instruction bits 6:2 only. The low two bits
 * are checked separately by the decoder.
 * inst_op_e is 6 bits wide and NOP must stay the first value, so a
 * cleared issue bundle reads as a bubble.
 */

package rv_decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  opcode_t;

    ////////////////////
    // Major opcodes
    ////////////////////
    localparam opcode_t OPC_LOAD     = 5'b00000;
    localparam opcode_t OPC_STORE    = 5'b01000;
    localparam opcode_t OPC_BRANCH   = 5'b11000;
    localparam opcode_t OPC_JAL      = 5'b11011;
    localparam opcode_t OPC_JALR     = 5'b11001;
    localparam opcode_t OPC_LUI      = 5'b01101;
    localparam opcode_t OPC_AUIPC    = 5'b00101;
    localparam opcode_t OPC_OP_IMM   = 5'b00100;
    localparam opcode_t OPC_OP       = 5'b01100;
    localparam opcode_t OPC_MISC_MEM = 5'b00011;
    localparam opcode_t OPC_SYSTEM   = 5'b11100;

    typedef enum logic [5:0] {
        NOP, INVALID,
        LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        // M extension
        MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
        // System group
        ECALL, EBREAK, SRET, MRET, WFI,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI
    } inst_op_e;

    typedef enum logic [2:0] {
        R_TYPE, I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE
    } inst_fmt_e;

    // Decoder result for one instruction
    typedef struct packed {
        inst_op_e  op;
        inst_fmt_e fmt;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_rs1;
        logic      use_rs2;
        logic      is_load;
        logic      is_store;
        logic      illegal;
        word_t     imm;
    } dec_info_t;

    // One write port seen by the forwarder
    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } fwd_src_t;

    // Registered bundle handed to execute
    typedef struct packed {
        inst_op_e  op;
        reg_addr_t rd;
        word_t     pc;
        word_t     instruction;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     second_operand;
    } issue_t;

endpackage

//--- sources.f
rtl/rv_decode_pkg.sv
rtl/op_decoder.sv
rtl/operand_forward.sv
rtl/issue_ctrl.sv
rtl/decode_top.sv
dv/tb_clock_gen.sv
dv/decode_tb.sv
